/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_periph_soc
FILELIST  := filelist.f
OBJDIR    := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/periph_soc_properties.sv */
`timescale 1ns/1ps

module periph_soc_properties (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         wb_cyc_i,
  input logic                         wb_stb_i,
  input logic                         wb_we_i,
  input logic                         wb_ack_o,
  input logic                         uart_tx_o,
  input logic                         spi_sck_o,
  input logic [periph_pkg::NumCs-1:0] spi_csb_o
);

  logic seen_write_q;

  // Set by the first bus write after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seen_write_q <= 1'b0;
    end else if (wb_cyc_i && wb_stb_i && wb_we_i) begin
      seen_write_q <= 1'b1;
    end
  end

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb_ack_o held for more than one cycle");

  // Ack answers a request that was open two clocks earlier
  ack_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i, 2))
    else $error("wb_ack_o raised without wb_cyc_i");

  uart_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !seen_write_q |-> uart_tx_o)
    else $error("uart_tx_o left idle before any write");

  // SCK only runs under exactly one selected device
  one_cs_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($countones(~spi_csb_o) <= 1) && (!spi_sck_o || $onehot(~spi_csb_o)))
    else $error("more than one chip select low, or SCK high with none selected");

endmodule

bind periph_soc periph_soc_properties u_props (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .wb_cyc_i  ( wb_cyc_i  ),
  .wb_stb_i  ( wb_stb_i  ),
  .wb_we_i   ( wb_we_i   ),
  .wb_ack_o  ( wb_ack_o  ),
  .uart_tx_o ( uart_tx_o ),
  .spi_sck_o ( spi_sck_o ),
  .spi_csb_o ( spi_csb_o )
);

/* dv/tb_periph_soc.sv */
`timescale 1ns/1ps

module tb_periph_soc;

  localparam int unsigned ClksPerBit = 16;
  localparam int unsigned SckHalf    = 4;
  localparam int unsigned QDepth     = 4;

  typedef enum int {
    KUartStat,
    KSpiStat,
    KUart,
    KSpi,
    KOverflow,
    KUnmapped,
    KBoth
  } kind_e;

  logic        clk;
  logic        rst_n;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [3:0]  adr;
  logic [31:0] wdat;
  logic [31:0] rdat;
  logic        ack;
  logic        uart_tx;
  logic        sck;
  logic        sd;
  logic [3:0]  csb;

  // Stimulus table columns
  string       t_name [$];
  kind_e       t_kind [$];
  logic [3:0]  t_adr  [$];
  logic [31:0] t_data [$];
  logic [31:0] t_exp  [$];

  periph_pkg::byte_t uart_rx_q [$];
  int unsigned       errors;
  int unsigned       failed_tests;
  int unsigned       cycles;
  int unsigned       limit;
  int unsigned       sck_edges;
  logic [31:0]       rng;

  periph_soc #(
    .ClksPerBit    ( ClksPerBit ),
    .SckHalfPeriod ( SckHalf    ),
    .QueueDepth    ( QDepth     )
  ) dut (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .wb_cyc_i  ( cyc     ),
    .wb_stb_i  ( stb     ),
    .wb_we_i   ( we      ),
    .wb_adr_i  ( adr     ),
    .wb_dat_i  ( wdat    ),
    .wb_dat_o  ( rdat    ),
    .wb_ack_o  ( ack     ),
    .uart_tx_o ( uart_tx ),
    .spi_sd_i  ( sd      ),
    .spi_sck_o ( sck     ),
    .spi_csb_o ( csb     ),
    .spi_sd_o  ( sd      )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [3:0] unit_adr(input logic spi, input int unsigned off);
    return {spi, 3'(off)};
  endfunction

  task automatic add_row(input string n, input kind_e k, input logic [3:0] a,
                         input logic [31:0] d, input logic [31:0] e);
    t_name.push_back(n);
    t_kind.push_back(k);
    t_adr.push_back(a);
    t_data.push_back(d);
    t_exp.push_back(e);
  endtask

  //////////////////////////////////////////////////
  // Wishbone host
  //////////////////////////////////////////////////

  task automatic wb_access(input logic w, input logic [3:0] a, input logic [31:0] d,
                           output logic [31:0] q);
    cyc  = 1'b1;
    stb  = 1'b1;
    we   = w;
    adr  = a;
    wdat = d;
    do @(negedge clk); while (!ack);
    q   = rdat;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(negedge clk);
  endtask

  task automatic wb_write(input logic [3:0] a, input logic [31:0] d);
    logic [31:0] unused;
    wb_access(1'b1, a, d, unused);
  endtask

  task automatic wb_read(input logic [3:0] a, output logic [31:0] q);
    wb_access(1'b0, a, '0, q);
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string n, input logic [31:0] e, input logic [31:0] a);
    if (a !== e) begin
      errors++;
      $display("Error: %s expected %h actual %h", n, e, a);
    end
  endtask

  task automatic check_byte(input string n, input periph_pkg::byte_t e,
                            input periph_pkg::byte_t a);
    if (a !== e) begin
      errors++;
      $display("Error: %s expected %h actual %h", n, e, a);
    end
  endtask

  task automatic check_uart_status(input string n, input periph_pkg::uart_status_t e,
                                   input periph_pkg::uart_status_t a);
    if (a !== e) begin
      errors++;
      $display("Error: %s expected %b actual %b", n, e, a);
    end
  endtask

  task automatic check_spi_status(input string n, input periph_pkg::spi_status_t e,
                                  input periph_pkg::spi_status_t a);
    if (a !== e) begin
      errors++;
      $display("Error: %s expected %b actual %b", n, e, a);
    end
  endtask

  //////////////////////////////////////////////////
  // Unit helpers
  //////////////////////////////////////////////////

  task automatic wait_uart_byte(output periph_pkg::byte_t b);
    while (uart_rx_q.size() == 0) @(negedge clk);
    b = uart_rx_q.pop_front();
  endtask

  task automatic wait_uart_idle();
    logic [31:0] q;
    periph_pkg::uart_status_t st;
    do begin
      wb_read(unit_adr(1'b0, soc_cfg_pkg::UartStatusOff), q);
      st = q[2:0];
    end while (st.busy || !st.empty);
  endtask

  task automatic spi_transfer(input string n, input logic [31:0] d);
    logic [31:0] q;
    logic [3:0]  exp_csb;
    int unsigned edges_before;
    periph_pkg::spi_status_t st;
    exp_csb       = '1;
    exp_csb[d[9:8]] = 1'b0;
    edges_before  = sck_edges;
    wb_write(unit_adr(1'b1, soc_cfg_pkg::SpiDataOff), d);
    while (csb == '1) @(negedge clk);
    check_word({n, "_csb"}, 32'(exp_csb), 32'(csb));
    do begin
      wb_read(unit_adr(1'b1, soc_cfg_pkg::SpiStatusOff), q);
      st = q[3:0];
    end while (st.busy || !st.empty);
    // One SCK period per data bit
    check_word({n, "_sck"}, 32'd8, 32'(sck_edges - edges_before));
    wb_read(unit_adr(1'b1, soc_cfg_pkg::SpiRxOff), q);
    // Loopback returns the byte that went out
    check_word({n, "_rx"}, {24'd0, d[7:0]}, q);
    wb_read(unit_adr(1'b1, soc_cfg_pkg::SpiStatusOff), q);
    st = '0;
    st.empty = 1'b1;
    check_spi_status({n, "_rx_clear"}, st, q[3:0]);
  endtask

  // SCK rising edges over the whole run
  initial begin
    sck_edges = 0;
    forever begin
      @(posedge sck);
      sck_edges++;
    end
  end

  // UART line decoder, samples mid-bit on the falling clock
  initial begin
    periph_pkg::byte_t b;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      repeat (ClksPerBit / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        errors++;
        $display("UART start bit did not hold low");
      end
      for (int i = 0; i < 8; i++) begin
        repeat (ClksPerBit) @(negedge clk);
        b[i] = uart_tx;
      end
      repeat (ClksPerBit) @(negedge clk);
      if (uart_tx !== 1'b1) begin
        errors++;
        $display("UART stop bit missing after byte %h", b);
      end
      uart_rx_q.push_back(b);
    end
  end

  // Watchdog
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (limit != 0 && cycles > limit) begin
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]       q;
    periph_pkg::byte_t b;
    periph_pkg::byte_t burst [$];
    periph_pkg::uart_status_t ust;
    int unsigned       frames;
    int unsigned       err_before;
    rst_n  = 1'b0;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    adr    = '0;
    wdat   = '0;
    errors = 0;
    failed_tests = 0;
    limit  = 0;
    rng    = 32'd78904;

    // Status after reset, full is the MSB of each word
    add_row("reset_uart_status", KUartStat, 4'h1, 0, 32'b010);
    add_row("reset_spi_status", KSpiStat, 4'hA, 0, 32'b0100);
    add_row("uart_a5", KUart, 4'h0, 32'hA5, 32'hA5);
    add_row("uart_3c", KUart, 4'h0, 32'h3C, 32'h3C);
    add_row("uart_rand", KUart, 4'h0, {24'd0, 8'(xorshift())}, 0);
    add_row("spi_cs0", KSpi, 4'h8, 32'h096, 0);
    add_row("spi_cs2", KSpi, 4'h8, 32'h25B, 0);
    add_row("spi_rand_cs3", KSpi, 4'h8, {22'd0, 2'd3, 8'(xorshift())}, 0);
    add_row("uart_overflow", KOverflow, 4'h0, 0, 0);
    add_row("unmapped_uart", KUnmapped, 4'h2, 0, 0);
    add_row("unmapped_spi", KUnmapped, 4'hB, 0, 0);
    add_row("uart_spi_together", KBoth, 4'h0, {22'd0, 2'd1, 8'(xorshift())}, 0);

    frames = 0;
    foreach (t_kind[i]) begin
      case (t_kind[i])
        KUart, KBoth: frames += 10 * ClksPerBit + 20 * SckHalf;
        KSpi:         frames += 20 * SckHalf;
        KOverflow:    frames += (QDepth + 2) * 10 * ClksPerBit;
        default:      frames += 0;
      endcase
    end
    limit = frames * 2 + 2000;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_word("reset_uart_tx", 32'd1, 32'(uart_tx));
    check_word("reset_spi_csb", 32'hF, 32'(csb));
    check_word("reset_spi_sck", 32'd0, 32'(sck));
    check_word("reset_spi_sd", 32'd0, 32'(sd));

    foreach (t_name[i]) begin
      err_before = errors;
      case (t_kind[i])
        KUartStat: begin
          wb_read(t_adr[i], q);
          check_uart_status(t_name[i], t_exp[i][2:0], q[2:0]);
        end
        KSpiStat: begin
          wb_read(t_adr[i], q);
          check_spi_status(t_name[i], t_exp[i][3:0], q[3:0]);
        end
        KUart: begin
          wb_write(t_adr[i], t_data[i]);
          wait_uart_byte(b);
          check_byte(t_name[i], t_data[i][7:0], b);
        end
        KSpi: spi_transfer(t_name[i], t_data[i]);
        KOverflow: begin
          // Serializer takes the first byte at once, the queue holds the next QDepth
          burst.delete();
          for (int k = 0; k < QDepth + 2; k++) begin
            burst.push_back(8'(xorshift()));
            wb_write(t_adr[i], {24'd0, burst[k]});
          end
          wb_read(4'h1, q);
          ust = '0;
          ust.full = 1'b1;
          ust.busy = 1'b1;
          check_uart_status({t_name[i], "_full"}, ust, q[2:0]);
          for (int k = 0; k < QDepth + 1; k++) begin
            wait_uart_byte(b);
            check_byte(t_name[i], burst[k], b);
          end
          wait_uart_idle();
          repeat (2 * ClksPerBit) @(negedge clk);
          if (uart_rx_q.size() != 0) begin
            errors++;
            $display("%s: the dropped byte was sent anyway", t_name[i]);
          end
        end
        KUnmapped: begin
          wb_read(t_adr[i], q);
          check_word(t_name[i], 32'd0, q);
        end
        KBoth: begin
          wb_write(4'h0, {24'd0, t_data[i][7:0] ^ 8'hFF});
          spi_transfer(t_name[i], t_data[i]);
          wait_uart_byte(b);
          check_byte(t_name[i], t_data[i][7:0] ^ 8'hFF, b);
        end
        default: ;
      endcase
      if (errors == err_before) begin
        $display("[pass] %s", t_name[i]);
      end else begin
        failed_tests++;
        $display("[fail] %s", t_name[i]);
      end
    end

    $display("Tests: %0d run, %0d failed, %0d errors", t_name.size(), failed_tests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
hw/soc_cfg_pkg.sv
hw/periph_pkg.sv
hw/periph_bus_if.sv
hw/tx_queue.sv
hw/uart_tx_unit.sv
hw/spi_host_unit.sv
hw/periph_bus_decoder.sv
hw/periph_soc.sv
dv/periph_soc_properties.sv
dv/tb_periph_soc.sv

/* hw/periph_bus_decoder.sv */
`timescale 1ns/1ps

module periph_bus_decoder (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [soc_cfg_pkg::WbAdrWidth-1:0]  wb_adr_i,
  input  logic [soc_cfg_pkg::WbDataWidth-1:0] wb_dat_i,
  output logic [soc_cfg_pkg::WbDataWidth-1:0] wb_dat_o,
  output logic                                wb_ack_o,
  periph_bus_if.host                          uart_bus,
  periph_bus_if.host                          spi_bus
);

  localparam int unsigned OffWidth = soc_cfg_pkg::OffWidth;

  logic                req_q;
  logic                start;
  logic                spi_hit;
  logic                in_range;
  logic                local_ack;
  logic [OffWidth-1:0] off;

  //////////////////////////////////////////////////
  // Access detection and routing
  //////////////////////////////////////////////////

  // New access only once ack has dropped again
  assign start = wb_cyc_i & wb_stb_i & ~req_q & ~wb_ack_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= start;
    end
  end

  assign off     = wb_adr_i[OffWidth-1:0];
  assign spi_hit = wb_adr_i[soc_cfg_pkg::UnitSelBit];

  assign in_range = spi_hit ? (off < OffWidth'(soc_cfg_pkg::SpiNumRegs))
                            : (off < OffWidth'(soc_cfg_pkg::UartNumRegs));

  // Host holds address and data, so these need no capture
  assign uart_bus.sel   = req_q & ~spi_hit & in_range;
  assign uart_bus.we    = wb_we_i;
  assign uart_bus.adr   = off;
  assign uart_bus.wdata = wb_dat_i;

  assign spi_bus.sel   = req_q & spi_hit & in_range;
  assign spi_bus.we    = wb_we_i;
  assign spi_bus.adr   = off;
  assign spi_bus.wdata = wb_dat_i;

  // Holes in the map answer here with zero data
  assign local_ack = req_q & ~in_range;

  //////////////////////////////////////////////////
  // Reply merge
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= (uart_bus.ack | spi_bus.ack | local_ack) & wb_cyc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (uart_bus.ack) begin
      wb_dat_o <= uart_bus.rdata;
    end else if (spi_bus.ack) begin
      wb_dat_o <= spi_bus.rdata;
    end else begin
      wb_dat_o <= '0;
    end
  end

endmodule

/* hw/periph_bus_if.sv */
`timescale 1ns/1ps

// Decoder to unit link, one access strobe per Wishbone cycle
interface periph_bus_if;

  // One-cycle strobe from the decoder
  logic sel;
  logic we;
  logic [soc_cfg_pkg::OffWidth-1:0] adr;
  logic [soc_cfg_pkg::WbDataWidth-1:0] wdata;

  // Unit reply, valid in the same cycle as sel
  logic [soc_cfg_pkg::WbDataWidth-1:0] rdata;
  logic ack;

  modport host (
    output sel,
    output we,
    output adr,
    output wdata,
    input  rdata,
    input  ack
  );

  modport unit (
    input  sel,
    input  we,
    input  adr,
    input  wdata,
    output rdata,
    output ack
  );

endinterface

/* hw/periph_pkg.sv */
package periph_pkg;

  // SPI chip select lines
  localparam int unsigned NumCs   = 4;
  localparam int unsigned CsWidth = $clog2(NumCs);

  // UART queue payload
  typedef logic [7:0] byte_t;

  //////////////////////////////////////////////////
  // SPI command
  //////////////////////////////////////////////////

  // Field order mirrors the data register, cs above data
  typedef struct packed {
    logic [CsWidth-1:0] cs;
    byte_t              data;
  } spi_cmd_t;

  //////////////////////////////////////////////////
  // Status words
  //////////////////////////////////////////////////

  // Read back in bits 2:0, full is the MSB
  typedef struct packed {
    logic full;
    logic empty;
    logic busy;
  } uart_status_t;

  // Read back in bits 3:0, rx_valid is the LSB
  typedef struct packed {
    logic full;
    logic empty;
    logic busy;
    logic rx_valid;
  } spi_status_t;

endpackage

/* hw/periph_soc.sv */
`timescale 1ns/1ps

module periph_soc #(
  parameter int unsigned ClksPerBit    = soc_cfg_pkg::DefClksPerBit,
  parameter int unsigned SckHalfPeriod = soc_cfg_pkg::DefSckHalfPeriod,
  parameter int unsigned QueueDepth    = soc_cfg_pkg::DefQueueDepth
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [soc_cfg_pkg::WbAdrWidth-1:0]  wb_adr_i,
  input  logic [soc_cfg_pkg::WbDataWidth-1:0] wb_dat_i,
  output logic [soc_cfg_pkg::WbDataWidth-1:0] wb_dat_o,
  output logic                                wb_ack_o,
  output logic                                uart_tx_o,
  input  logic                                spi_sd_i,
  output logic                                spi_sck_o,
  output logic [periph_pkg::NumCs-1:0]        spi_csb_o,
  output logic                                spi_sd_o
);

  // One link per unit
  periph_bus_if uart_bus ();
  periph_bus_if spi_bus ();

  periph_bus_decoder u_decoder (
    .clk_i    ( clk_i    ),
    .rst_n_i  ( rst_n_i  ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_we_i  ( wb_we_i  ),
    .wb_adr_i ( wb_adr_i ),
    .wb_dat_i ( wb_dat_i ),
    .wb_dat_o ( wb_dat_o ),
    .wb_ack_o ( wb_ack_o ),
    .uart_bus ( uart_bus ),
    .spi_bus  ( spi_bus  )
  );

  uart_tx_unit #(
    .ClksPerBit ( ClksPerBit ),
    .QueueDepth ( QueueDepth )
  ) u_uart (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .bus     ( uart_bus  ),
    .tx_o    ( uart_tx_o )
  );

  spi_host_unit #(
    .SckHalfPeriod ( SckHalfPeriod ),
    .QueueDepth    ( QueueDepth    )
  ) u_spi (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .bus       ( spi_bus   ),
    .spi_sd_i  ( spi_sd_i  ),
    .spi_sck_o ( spi_sck_o ),
    .spi_csb_o ( spi_csb_o ),
    .spi_sd_o  ( spi_sd_o  )
  );

endmodule

/* hw/soc_cfg_pkg.sv */
package soc_cfg_pkg;

  //////////////////////////////////////////////////
  // Host bus geometry
  //////////////////////////////////////////////////

  localparam int unsigned WbAdrWidth  = 4;
  localparam int unsigned WbDataWidth = 32;

  // Word offset inside one unit
  localparam int unsigned OffWidth = 3;

  // Address bit that picks the unit, 0 is UART and 1 is SPI
  localparam int unsigned UnitSelBit = 3;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam logic [OffWidth-1:0] UartDataOff   = OffWidth'(0);
  localparam logic [OffWidth-1:0] UartStatusOff = OffWidth'(1);
  localparam int unsigned         UartNumRegs   = 2;

  // Data write carries the byte in 7:0 and chip select in 9:8
  localparam logic [OffWidth-1:0] SpiDataOff   = OffWidth'(0);
  localparam logic [OffWidth-1:0] SpiRxOff     = OffWidth'(1);
  localparam logic [OffWidth-1:0] SpiStatusOff = OffWidth'(2);
  localparam int unsigned         SpiNumRegs   = 3;

  // Defaults for the top-level parameters
  localparam int unsigned DefClksPerBit    = 16;
  localparam int unsigned DefSckHalfPeriod = 4;
  localparam int unsigned DefQueueDepth    = 4;

endpackage

/* hw/spi_host_unit.sv */
`timescale 1ns/1ps

module spi_host_unit #(
  parameter int unsigned SckHalfPeriod = soc_cfg_pkg::DefSckHalfPeriod,
  parameter int unsigned QueueDepth    = soc_cfg_pkg::DefQueueDepth
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  periph_bus_if.unit                   bus,
  input  logic                         spi_sd_i,
  output logic                         spi_sck_o,
  output logic [periph_pkg::NumCs-1:0] spi_csb_o,
  output logic                         spi_sd_o
);

  localparam int unsigned DivWidth = (SckHalfPeriod > 1) ? $clog2(SckHalfPeriod) : 1;

  typedef enum logic [1:0] {
    SpiIdle,
    SpiLead,
    SpiShift,
    SpiTrail
  } spi_state_e;

  spi_state_e                       state_q;
  logic [DivWidth-1:0]              div_q;
  logic [2:0]                       bit_q;
  logic                             sck_q;
  logic                             sample_q;
  logic [periph_pkg::CsWidth-1:0]   cs_q;
  periph_pkg::byte_t                shift_q;
  periph_pkg::byte_t                rx_data_q;
  logic                             rx_valid_q;
  periph_pkg::spi_cmd_t             cmd_in;
  periph_pkg::spi_cmd_t             q_head;
  periph_pkg::spi_status_t          status;
  logic                             push;
  logic                             pop;
  logic                             rx_read;
  logic                             q_full;
  logic                             q_empty;
  logic                             half_done;
  logic                             sck_rise;
  logic                             sck_fall;
  logic                             xfer_done;

  //////////////////////////////////////////////////
  // Register block
  //////////////////////////////////////////////////

  assign push    = bus.sel & bus.we & (bus.adr == soc_cfg_pkg::SpiDataOff);
  assign rx_read = bus.sel & ~bus.we & (bus.adr == soc_cfg_pkg::SpiRxOff);
  assign bus.ack = bus.sel;

  assign cmd_in.data = bus.wdata[7:0];
  assign cmd_in.cs   = bus.wdata[8 +: periph_pkg::CsWidth];

  always_comb begin
    status          = '0;
    status.full     = q_full;
    status.empty    = q_empty;
    status.busy     = (state_q != SpiIdle);
    status.rx_valid = rx_valid_q;
    bus.rdata = '0;
    case (bus.adr)
      soc_cfg_pkg::SpiRxOff:     bus.rdata[7:0] = rx_data_q;
      soc_cfg_pkg::SpiStatusOff: bus.rdata[$bits(status)-1:0] = status;
      default: ;
    endcase
  end

  tx_queue #(
    .payload_t ( periph_pkg::spi_cmd_t ),
    .Depth     ( QueueDepth            )
  ) u_queue (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .push_i  ( push    ),
    .wdata_i ( cmd_in  ),
    .pop_i   ( pop     ),
    .rdata_o ( q_head  ),
    .full_o  ( q_full  ),
    .empty_o ( q_empty )
  );

  //////////////////////////////////////////////////
  // Mode-0 shift engine
  //////////////////////////////////////////////////

  assign half_done = (div_q == DivWidth'(SckHalfPeriod - 1));
  assign pop       = (state_q == SpiIdle) & ~q_empty;
  // First rising edge closes the lead-in half period
  assign sck_rise  = half_done & ((state_q == SpiLead) | ((state_q == SpiShift) & ~sck_q));
  assign sck_fall  = half_done & (state_q == SpiShift) & sck_q;
  assign xfer_done = half_done & (state_q == SpiTrail);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= SpiIdle;
      div_q      <= '0;
      bit_q      <= '0;
      sck_q      <= 1'b0;
      cs_q       <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      div_q <= ((state_q == SpiIdle) || half_done) ? '0 : div_q + DivWidth'(1);
      if (sck_rise) sck_q <= 1'b1;
      if (sck_fall) sck_q <= 1'b0;
      case (state_q)
        SpiIdle: begin
          if (pop) begin
            state_q <= SpiLead;
            cs_q    <= q_head.cs;
          end
        end
        SpiLead: if (half_done) state_q <= SpiShift;
        SpiShift: begin
          if (sck_fall) begin
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) state_q <= SpiTrail;
          end
        end
        SpiTrail: if (half_done) state_q <= SpiIdle;
        default: state_q <= SpiIdle;
      endcase
      // A finishing transfer wins over a clearing read
      if (xfer_done) begin
        rx_valid_q <= 1'b1;
      end else if (rx_read) begin
        rx_valid_q <= 1'b0;
      end
    end
  end

  // Out at the MSB, in at the LSB
  always_ff @(posedge clk_i) begin
    if (pop) begin
      shift_q <= q_head.data;
    end else if (sck_fall) begin
      shift_q <= {shift_q[6:0], sample_q};
    end
    if (sck_rise) sample_q <= spi_sd_i;
    if (xfer_done) rx_data_q <= shift_q;
  end

  always_comb begin
    spi_csb_o = '1;
    if (state_q != SpiIdle) begin
      spi_csb_o[cs_q] = 1'b0;
    end
  end

  assign spi_sck_o = sck_q;
  assign spi_sd_o  = (state_q != SpiIdle) & shift_q[7];

endmodule

/* hw/tx_queue.sv */
`timescale 1ns/1ps

module tx_queue #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t wdata_i,
  input  logic     pop_i,
  output payload_t rdata_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t            mem [Depth];
  logic [PtrWidth-1:0] wr_ptr;
  logic [PtrWidth-1:0] rd_ptr;
  logic [CntWidth-1:0] count;
  logic                do_push;
  logic                do_pop;

  // Wrap at Depth, also for depths that are not a power of two
  function automatic logic [PtrWidth-1:0] ptr_next(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + PtrWidth'(1);
  endfunction

  assign full_o  = (count == CntWidth'(Depth));
  assign empty_o = (count == '0);

  // Overflow and underflow requests are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head entry straight from storage
  assign rdata_o = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + CntWidth'(1);
      end else if (do_pop && !do_push) begin
        count <= count - CntWidth'(1);
      end
    end
  end

endmodule

/* hw/uart_tx_unit.sv */
`timescale 1ns/1ps

module uart_tx_unit #(
  parameter int unsigned ClksPerBit = soc_cfg_pkg::DefClksPerBit,
  parameter int unsigned QueueDepth = soc_cfg_pkg::DefQueueDepth
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  periph_bus_if.unit bus,
  output logic       tx_o
);

  localparam int unsigned DivWidth = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;

  typedef enum logic [1:0] {
    TxIdle,
    TxStart,
    TxData,
    TxStop
  } tx_state_e;

  tx_state_e                 state_q;
  logic [DivWidth-1:0]       div_q;
  logic [2:0]                bit_q;
  periph_pkg::byte_t         shift_q;
  periph_pkg::byte_t         q_head;
  periph_pkg::uart_status_t  status;
  logic                      push;
  logic                      pop;
  logic                      q_full;
  logic                      q_empty;
  logic                      bit_done;

  //////////////////////////////////////////////////
  // Register block
  //////////////////////////////////////////////////

  assign push    = bus.sel & bus.we & (bus.adr == soc_cfg_pkg::UartDataOff);
  assign bus.ack = bus.sel;

  always_comb begin
    status       = '0;
    status.full  = q_full;
    status.empty = q_empty;
    status.busy  = (state_q != TxIdle);
    // Data register is write-only and reads as zero
    bus.rdata = '0;
    if (bus.adr == soc_cfg_pkg::UartStatusOff) begin
      bus.rdata[$bits(status)-1:0] = status;
    end
  end

  tx_queue #(
    .payload_t ( periph_pkg::byte_t ),
    .Depth     ( QueueDepth         )
  ) u_queue (
    .clk_i   ( clk_i           ),
    .rst_n_i ( rst_n_i         ),
    .push_i  ( push            ),
    .wdata_i ( bus.wdata[7:0]  ),
    .pop_i   ( pop             ),
    .rdata_o ( q_head          ),
    .full_o  ( q_full          ),
    .empty_o ( q_empty         )
  );

  //////////////////////////////////////////////////
  // 8N1 serializer
  //////////////////////////////////////////////////

  assign bit_done = (div_q == DivWidth'(ClksPerBit - 1));

  // Next frame starts from idle or right after a stop bit
  assign pop = ~q_empty & ((state_q == TxIdle) | ((state_q == TxStop) & bit_done));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= TxIdle;
      div_q   <= '0;
      bit_q   <= '0;
    end else begin
      div_q <= ((state_q == TxIdle) || bit_done) ? '0 : div_q + DivWidth'(1);
      case (state_q)
        TxIdle: if (pop) state_q <= TxStart;
        TxStart: if (bit_done) state_q <= TxData;
        TxData: begin
          if (bit_done) begin
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) state_q <= TxStop;
          end
        end
        TxStop: if (bit_done) state_q <= pop ? TxStart : TxIdle;
        default: state_q <= TxIdle;
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clk_i) begin
    if (pop) begin
      shift_q <= q_head;
    end else if ((state_q == TxData) && bit_done) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  always_comb begin
    case (state_q)
      TxStart: tx_o = 1'b0;
      TxData:  tx_o = shift_q[0];
      default: tx_o = 1'b1;
    endcase
  end

endmodule
